// File: hdl/step_motor_pkg.sv
`default_nettype none

package step_motor_pkg;

	// step count, also used for the axis position
	typedef logic [15:0] step_num_t;

	// half-period in enable ticks
	typedef logic [15:0] speed_t;

	// speed table address, 512 entries
	typedef logic [8:0] speed_addr_t;

	// driver chip microstep select
	typedef logic [2:0] microstep_t;

	// upper bit doubles as the busy flag
	typedef enum logic [1:0] {
		MOTOR_IDLE    = 2'b00,
		MOTOR_PREPARE = 2'b10,
		MOTOR_RUNNING = 2'b11
	} motor_state_e;

endpackage

`default_nettype wire

// File: hdl/step_clk_divider.sv
`timescale 1ns/100ps
`default_nettype none

module step_clk_divider #(
	parameter integer C_CLK_DIV = 8
) (
	input  wire clk,
	input  wire resetn,
	output logic o_clk_en
);
	localparam integer C_CNT_W = $clog2(C_CLK_DIV);

	logic [C_CNT_W-1:0] div_cnt;

	// one pulse per wrap
	always_ff @(posedge clk) begin
		if (!resetn) begin
			div_cnt <= '0;
			o_clk_en <= 1'b0;
		end else if (div_cnt == C_CNT_W'(C_CLK_DIV - 1)) begin
			div_cnt <= '0;
			o_clk_en <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			o_clk_en <= 1'b0;
		end
	end

	a_clk_en_single: assert property (@(posedge clk) disable iff (!resetn)
		o_clk_en |=> !o_clk_en)
		else $error("clk_en high on two consecutive cycles");

endmodule

`default_nettype wire

// File: hdl/speed_table.sv
`timescale 1ns/100ps
`default_nettype none

module speed_table (
	input  wire clk,
	input  wire i_wr_en,
	input  wire step_motor_pkg::speed_addr_t i_wr_addr,
	input  wire step_motor_pkg::speed_t i_wr_data,
	input  wire i_rd_en,
	input  wire step_motor_pkg::speed_addr_t i_rd_addr,
	output step_motor_pkg::speed_t o_rd_data
);
	import step_motor_pkg::*;

	speed_t mem [512];
	speed_addr_t rd_addr_q;
	logic rd_en_q;

	// host write port
	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// address stage, then data stage
	always_ff @(posedge clk) begin
		rd_en_q <= i_rd_en;
		if (i_rd_en)
			rd_addr_q <= i_rd_addr;
	end

	// output holds until the next read
	always_ff @(posedge clk) begin
		if (rd_en_q)
			o_rd_data <= mem[rd_addr_q];
	end

endmodule

`default_nettype wire

// File: hdl/step_motor_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module step_motor_ctrl #(
	parameter integer C_REVERSE_DELAY = 4
) (
	input  wire clk,
	input  wire resetn,
	input  wire i_clk_en,
	input  wire step_motor_pkg::speed_addr_t i_acce_addr_max,
	input  wire step_motor_pkg::speed_addr_t i_deac_addr_max,
	output logic o_rd_en,
	output step_motor_pkg::speed_addr_t o_acce_addr,
	output step_motor_pkg::speed_addr_t o_deac_addr,
	input  wire step_motor_pkg::speed_t i_acce_data,
	input  wire step_motor_pkg::speed_t i_deac_data,
	input  wire i_zpd,
	input  wire i_tpsign,
	input  wire step_motor_pkg::speed_t i_speed,
	input  wire step_motor_pkg::step_num_t i_step,
	input  wire i_start,
	input  wire i_stop,
	input  wire i_dir,
	input  wire step_motor_pkg::microstep_t i_ms,
	output logic o_drive,
	output logic o_dir,
	output step_motor_pkg::microstep_t o_ms,
	output logic o_busy
);
	import step_motor_pkg::*;

	localparam integer C_RD_W = $clog2(C_REVERSE_DELAY);

	motor_state_e motor_state;
	logic start_d1;
	logic start_pend;
	logic stop_d1;
	logic stop_pend;
	logic should_start;
	logic should_stop;
	logic step_done;
	logic [C_RD_W-1:0] reverse_cnt;
	step_num_t step_cnt;
	step_num_t step_remain;
	speed_t speed_max;
	speed_t speed_var;
	speed_t speed_cur;
	speed_t speed_cnt;
	logic rd_en_d1;
	logic rd_en_d2;
	logic rd_en_d3;

	assign o_busy = motor_state[1];
	assign should_start = i_clk_en && start_pend && !o_busy;

	// forward is dir low
	assign should_stop = (step_done && speed_cnt == '0)
		|| (i_tpsign && !o_dir)
		|| (i_zpd && o_dir);

	assign o_acce_addr = (step_cnt > step_num_t'(i_acce_addr_max)) ?
		i_acce_addr_max : speed_addr_t'(step_cnt);
	assign o_deac_addr = (step_remain > step_num_t'(i_deac_addr_max)) ?
		i_deac_addr_max : speed_addr_t'(step_remain);

	// start and stop edges, held until the next tick
	always_ff @(posedge clk) begin
		if (!resetn) begin
			start_d1 <= 1'b0;
			stop_d1 <= 1'b0;
			start_pend <= 1'b0;
			stop_pend <= 1'b0;
		end else begin
			start_d1 <= i_start;
			stop_d1 <= i_stop;
			if (start_pend) begin
				if (i_clk_en)
					start_pend <= 1'b0;
			end else if (i_start && !start_d1 && !o_busy) begin
				start_pend <= 1'b1;
			end
			if (stop_pend) begin
				if (i_clk_en)
					stop_pend <= 1'b0;
			end else if (i_stop && !stop_d1 && o_busy) begin
				stop_pend <= 1'b1;
			end
		end
	end

	// move parameters
	always_ff @(posedge clk) begin
		if (should_start) begin
			speed_max <= i_speed;
			o_ms <= i_ms;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			o_dir <= 1'b0;
		else if (should_start)
			o_dir <= i_dir;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			motor_state <= MOTOR_IDLE;
			reverse_cnt <= '0;
		end else if (i_clk_en) begin
			case (motor_state)
				MOTOR_IDLE: begin
					reverse_cnt <= '0;
					if (start_pend)
						motor_state <= (o_dir == i_dir) ? MOTOR_RUNNING : MOTOR_PREPARE;
				end
				MOTOR_PREPARE: begin
					// dead time after a direction change
					reverse_cnt <= reverse_cnt + 1'b1;
					if (stop_pend)
						motor_state <= MOTOR_IDLE;
					else if (reverse_cnt == C_RD_W'(C_REVERSE_DELAY - 2))
						motor_state <= MOTOR_RUNNING;
				end
				MOTOR_RUNNING: begin
					if (stop_pend || should_stop)
						motor_state <= MOTOR_IDLE;
				end
				default: motor_state <= MOTOR_IDLE;
			endcase
		end
	end

	// table read at start and on every falling drive edge
	always_ff @(posedge clk) begin
		if (!resetn)
			o_rd_en <= 1'b0;
		else if (o_rd_en)
			o_rd_en <= 1'b0;
		else if (i_clk_en)
			case (motor_state)
				MOTOR_IDLE: o_rd_en <= start_pend;
				MOTOR_RUNNING: o_rd_en <= (speed_cnt == '0) && o_drive;
				default: o_rd_en <= 1'b0;
			endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rd_en_d1 <= 1'b0;
			rd_en_d2 <= 1'b0;
			rd_en_d3 <= 1'b0;
		end else begin
			rd_en_d1 <= o_rd_en;
			rd_en_d2 <= rd_en_d1;
			rd_en_d3 <= rd_en_d2;
		end
	end

	// slowest of the two tables, then of the speed limit
	always_ff @(posedge clk) begin
		if (rd_en_d2)
			speed_var <= (i_acce_data > i_deac_data) ? i_acce_data : i_deac_data;
		if (rd_en_d3)
			speed_cur <= (speed_var > speed_max) ? speed_var : speed_max;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			step_cnt <= '0;
			step_remain <= '0;
			step_done <= 1'b0;
		end else if (i_clk_en) begin
			if (motor_state == MOTOR_RUNNING) begin
				if (speed_cnt == '0 && o_drive) begin
					step_cnt <= step_cnt + 1'b1;
					step_remain <= step_remain - 1'b1;
					if (step_remain == '0)
						step_done <= 1'b1;
				end
			end else begin
				step_done <= 1'b0;
				if (motor_state == MOTOR_IDLE && start_pend) begin
					step_cnt <= '0;
					step_remain <= i_step - 1'b1;
				end
			end
		end
	end

	// half-period counter and drive toggle
	always_ff @(posedge clk) begin
		if (!resetn) begin
			speed_cnt <= '0;
			o_drive <= 1'b0;
		end else if (i_clk_en) begin
			case (motor_state)
				MOTOR_RUNNING: begin
					speed_cnt <= (speed_cnt == '0) ? speed_cur : speed_cnt - 1'b1;
					if (stop_pend || should_stop)
						o_drive <= 1'b0;
					else if (speed_cnt == '0 && !step_done)
						o_drive <= ~o_drive;
				end
				MOTOR_IDLE: begin
					speed_cnt <= '0;
					o_drive <= 1'b0;
				end
				default: o_drive <= 1'b0;
			endcase
		end
	end

	a_drive_only_running: assert property (@(posedge clk) disable iff (!resetn)
		(motor_state != MOTOR_RUNNING) |-> !o_drive)
		else $error("drive high outside RUNNING");

	a_rd_en_single: assert property (@(posedge clk) disable iff (!resetn)
		o_rd_en |=> !o_rd_en)
		else $error("table read strobe longer than one cycle");

endmodule

`default_nettype wire

// File: hdl/position_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module position_tracker #(
	parameter integer C_INIT_POSITION = 1
) (
	input  wire clk,
	input  wire resetn,
	input  wire i_drive,
	input  wire i_dir,
	input  wire i_zpd,
	input  wire step_motor_pkg::step_num_t i_stroke,
	output step_motor_pkg::step_num_t o_position,
	output logic o_tpsign
);
	import step_motor_pkg::*;

	localparam step_num_t C_INIT = step_num_t'(C_INIT_POSITION);

	logic drive_d1;
	logic drive_fall;
	logic at_stroke;

	assign drive_fall = drive_d1 && !i_drive;
	assign at_stroke = (o_position == i_stroke);

	always_ff @(posedge clk) begin
		if (!resetn)
			drive_d1 <= 1'b0;
		else
			drive_d1 <= i_drive;
	end

	// zero sensor has priority over stepping
	always_ff @(posedge clk) begin
		if (!resetn || i_zpd) begin
			o_position <= C_INIT;
		end else if (drive_fall) begin
			if (!i_dir) begin
				if (!at_stroke)
					o_position <= o_position + 1'b1;
			end else if (o_position > C_INIT) begin
				o_position <= o_position - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			o_tpsign <= 1'b0;
		else if (drive_fall)
			o_tpsign <= at_stroke;
	end

	a_position_in_stroke: assert property (@(posedge clk) disable iff (!resetn)
		(i_stroke != '0 && o_position <= i_stroke)
		|=> (!$stable(i_stroke) || o_position <= i_stroke))
		else $error("position beyond stroke");

endmodule

`default_nettype wire

// File: hdl/step_motor_top.sv
`timescale 1ns/100ps
`default_nettype none

module step_motor_top #(
	parameter integer C_CLK_DIV = 8,
	parameter integer C_REVERSE_DELAY = 4,
	parameter integer C_INIT_POSITION = 1
) (
	input  wire clk,
	input  wire resetn,
	input  wire i_acce_wr,
	input  wire step_motor_pkg::speed_addr_t i_acce_wr_addr,
	input  wire step_motor_pkg::speed_t i_acce_wr_data,
	input  wire i_deac_wr,
	input  wire step_motor_pkg::speed_addr_t i_deac_wr_addr,
	input  wire step_motor_pkg::speed_t i_deac_wr_data,
	input  wire step_motor_pkg::speed_addr_t i_acce_addr_max,
	input  wire step_motor_pkg::speed_addr_t i_deac_addr_max,
	input  wire step_motor_pkg::speed_t i_speed,
	input  wire step_motor_pkg::step_num_t i_step,
	input  wire i_start,
	input  wire i_stop,
	input  wire i_dir,
	input  wire step_motor_pkg::microstep_t i_ms,
	input  wire step_motor_pkg::step_num_t i_stroke,
	input  wire i_zpd,
	input  wire i_xen,
	input  wire i_xrst,
	output logic o_drive,
	output logic o_dir,
	output step_motor_pkg::microstep_t o_ms,
	output logic o_busy,
	output step_motor_pkg::step_num_t o_position,
	output logic o_tpsign,
	output logic o_zpsign,
	output logic o_xen,
	output logic o_xrst
);
	import step_motor_pkg::*;

	logic clk_en;
	logic rd_en;
	speed_addr_t acce_addr;
	speed_addr_t deac_addr;
	speed_t acce_data;
	speed_t deac_data;

	// driver chip lines
	assign o_zpsign = i_zpd;
	assign o_xen = i_xen;
	assign o_xrst = i_xrst;

	step_clk_divider #(
		.C_CLK_DIV(C_CLK_DIV)
	) u_divider (
		.clk     (clk),
		.resetn  (resetn),
		.o_clk_en(clk_en)
	);

	speed_table u_acce_table (
		.clk      (clk),
		.i_wr_en  (i_acce_wr),
		.i_wr_addr(i_acce_wr_addr),
		.i_wr_data(i_acce_wr_data),
		.i_rd_en  (rd_en),
		.i_rd_addr(acce_addr),
		.o_rd_data(acce_data)
	);

	speed_table u_deac_table (
		.clk      (clk),
		.i_wr_en  (i_deac_wr),
		.i_wr_addr(i_deac_wr_addr),
		.i_wr_data(i_deac_wr_data),
		.i_rd_en  (rd_en),
		.i_rd_addr(deac_addr),
		.o_rd_data(deac_data)
	);

	step_motor_ctrl #(
		.C_REVERSE_DELAY(C_REVERSE_DELAY)
	) u_ctrl (
		.clk            (clk),
		.resetn         (resetn),
		.i_clk_en       (clk_en),
		.i_acce_addr_max(i_acce_addr_max),
		.i_deac_addr_max(i_deac_addr_max),
		.o_rd_en        (rd_en),
		.o_acce_addr    (acce_addr),
		.o_deac_addr    (deac_addr),
		.i_acce_data    (acce_data),
		.i_deac_data    (deac_data),
		.i_zpd          (i_zpd),
		.i_tpsign       (o_tpsign),
		.i_speed        (i_speed),
		.i_step         (i_step),
		.i_start        (i_start),
		.i_stop         (i_stop),
		.i_dir          (i_dir),
		.i_ms           (i_ms),
		.o_drive        (o_drive),
		.o_dir          (o_dir),
		.o_ms           (o_ms),
		.o_busy         (o_busy)
	);

	position_tracker #(
		.C_INIT_POSITION(C_INIT_POSITION)
	) u_tracker (
		.clk       (clk),
		.resetn    (resetn),
		.i_drive   (o_drive),
		.i_dir     (o_dir),
		.i_zpd     (i_zpd),
		.i_stroke  (i_stroke),
		.o_position(o_position),
		.o_tpsign  (o_tpsign)
	);

endmodule

`default_nettype wire

// File: tests/step_motor_checker.sv
`timescale 1ns/100ps
`default_nettype none

module step_motor_checker #(
	parameter integer C_CLK_DIV = 8,
	parameter integer C_REVERSE_DELAY = 4
) (
	input  wire clk,
	input  wire resetn,
	input  wire i_zpd,
	input  wire i_xen,
	input  wire i_xrst,
	input  wire i_drive,
	input  wire i_dir,
	input  wire step_motor_pkg::microstep_t i_ms,
	input  wire i_busy,
	input  wire step_motor_pkg::step_num_t i_position,
	input  wire i_tpsign,
	input  wire i_zpsign,
	input  wire i_xen_pass,
	input  wire i_xrst_pass,
	output int o_value_errs,
	output int o_other_errs,
	output int o_moves_done
);
	import step_motor_pkg::*;

	logic [15:0] stim_mem [256];
	speed_t acce_tab [512];
	speed_t deac_tab [512];
	speed_addr_t acce_max;
	speed_addr_t deac_max;
	int n_tab;
	int n_moves;
	int move_base;
	int move_idx;
	int rise_cnt;
	int phase_cyc;
	int busy_cyc;
	int pos_wait;
	int idx;
	logic [15:0] cur_id;
	speed_t cur_speed;
	step_num_t cur_steps;
	logic cur_dir;
	microstep_t cur_ms;
	step_num_t cur_stop;
	step_num_t cur_zero;
	step_num_t cur_exp_steps;
	step_num_t cur_exp_pos;
	logic reversal;
	logic last_dir;
	logic prev_drive;
	logic prev_busy;
	step_num_t prev_pos;

	initial begin
		for (idx = 0; idx < 512; idx++) begin
			acce_tab[idx] = '0;
			deac_tab[idx] = '0;
		end
		$readmemh("tests/step_motor_stim.txt", stim_mem);
		n_tab = stim_mem[0];
		n_moves = stim_mem[1];
		acce_max = speed_addr_t'(stim_mem[2]);
		deac_max = speed_addr_t'(stim_mem[3]);
		for (idx = 0; idx < n_tab; idx++) begin
			acce_tab[stim_mem[4 + 3 * idx]] = stim_mem[5 + 3 * idx];
			deac_tab[stim_mem[4 + 3 * idx]] = stim_mem[6 + 3 * idx];
		end
		move_base = 4 + 3 * n_tab;
	end

	// slowest of both clamped table entries and the speed limit, plus one
	function automatic int half_period_ticks(input int k);
		step_num_t remain;
		speed_t a;
		speed_t d;
		speed_t s;
		remain = step_num_t'(cur_steps - 1 - k);
		a = (k > acce_max) ? acce_tab[acce_max] : acce_tab[k];
		d = (remain > deac_max) ? deac_tab[deac_max] : deac_tab[remain];
		s = cur_speed;
		if (a > s)
			s = a;
		if (d > s)
			s = d;
		return s + 1;
	endfunction

	task report_value(input string what, input int expected, input int actual);
		o_value_errs++;
		$display("ERR test %0d %s: expected %0d, actual %0d", cur_id, what, expected, actual);
	endtask

	task report_other(input string msg);
		o_other_errs++;
		$display("test %0d at %0t: %s", cur_id, $time, msg);
	endtask

	task start_move();
		int base;
		base = move_base + 10 * move_idx;
		if (move_idx >= n_moves) begin
			report_other("busy rose with no move left in the stim file");
		end else begin
			cur_id = stim_mem[base];
			cur_speed = stim_mem[base + 1];
			cur_steps = stim_mem[base + 2];
			cur_dir = stim_mem[base + 3][0];
			cur_ms = microstep_t'(stim_mem[base + 4]);
			cur_stop = stim_mem[base + 6];
			cur_zero = stim_mem[base + 7];
			cur_exp_steps = stim_mem[base + 8];
			cur_exp_pos = stim_mem[base + 9];
		end
		if (i_dir !== cur_dir)
			report_value("direction", cur_dir, i_dir);
		if (i_ms !== cur_ms)
			report_value("microstep code", cur_ms, i_ms);
		reversal = (cur_dir != last_dir);
		last_dir = cur_dir;
		rise_cnt = 0;
		phase_cyc = 0;
		busy_cyc = 0;
	endtask

	task check_rise();
		if (rise_cnt == 0) begin
			if (reversal && busy_cyc <= (C_REVERSE_DELAY - 1) * C_CLK_DIV)
				report_other("drive edge inside the reverse dead time");
		end else if (phase_cyc != half_period_ticks(rise_cnt - 1) * C_CLK_DIV) begin
			report_value("low half-period cycles",
				half_period_ticks(rise_cnt - 1) * C_CLK_DIV, phase_cyc);
		end
		rise_cnt++;
		phase_cyc = 0;
	endtask

	task check_fall();
		if (phase_cyc != half_period_ticks(rise_cnt - 1) * C_CLK_DIV)
			report_value("high half-period cycles",
				half_period_ticks(rise_cnt - 1) * C_CLK_DIV, phase_cyc);
		phase_cyc = 0;
	endtask

	task end_move();
		if (i_drive)
			report_other("drive still high after busy fell");
		// a stop edge may land one step late
		if (cur_stop != 0) begin
			if (rise_cnt != cur_exp_steps && rise_cnt != cur_exp_steps + 1)
				report_value("step count", cur_exp_steps, rise_cnt);
		end else if (rise_cnt != cur_exp_steps) begin
			report_value("step count", cur_exp_steps, rise_cnt);
		end
		move_idx++;
		pos_wait = 3;
	endtask

	task check_final();
		if (i_position !== cur_exp_pos)
			report_value("final position", cur_exp_pos, i_position);
		// forward move cut short by the stroke end
		if (!cur_dir && cur_stop == 0 && cur_zero == 0 && cur_exp_steps < cur_steps
				&& !i_tpsign)
			report_other("terminal flag not raised at the stroke end");
		o_moves_done++;
	endtask

	always @(negedge clk) begin
		if (!resetn) begin
			o_value_errs = 0;
			o_other_errs = 0;
			o_moves_done = 0;
			move_idx = 0;
			rise_cnt = 0;
			phase_cyc = 0;
			busy_cyc = 0;
			pos_wait = 0;
			cur_id = '0;
			last_dir = 1'b0;
			prev_drive = 1'b0;
			prev_busy = 1'b0;
			prev_pos = i_position;
		end else begin
			if (i_zpsign !== i_zpd || i_xen_pass !== i_xen || i_xrst_pass !== i_xrst)
				report_other("driver lines do not follow their inputs");
			if (!i_zpd && i_position != prev_pos && i_position != prev_pos + 1'b1
					&& i_position != prev_pos - 1'b1)
				report_other("position jumped by more than one");
			phase_cyc++;
			busy_cyc++;
			if (i_busy && !prev_busy) begin
				start_move();
			end else if (i_busy) begin
				if (i_drive && !prev_drive)
					check_rise();
				if (!i_drive && prev_drive)
					check_fall();
			end
			if (!i_busy && prev_busy)
				end_move();
			if (pos_wait == 1)
				check_final();
			if (pos_wait > 0)
				pos_wait--;
			prev_drive = i_drive;
			prev_busy = i_busy;
			prev_pos = i_position;
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_step_motor.sv
`timescale 1ns/100ps
`default_nettype none

module tb_step_motor;
	import step_motor_pkg::*;

	localparam integer C_CLK_DIV = 8;
	localparam integer C_REVERSE_DELAY = 4;
	localparam integer C_INIT_POSITION = 1;
	localparam integer C_GAP_MAX = 20;

	logic clk;
	logic resetn;
	logic i_acce_wr;
	speed_addr_t i_acce_wr_addr;
	speed_t i_acce_wr_data;
	logic i_deac_wr;
	speed_addr_t i_deac_wr_addr;
	speed_t i_deac_wr_data;
	speed_addr_t i_acce_addr_max;
	speed_addr_t i_deac_addr_max;
	speed_t i_speed;
	step_num_t i_step;
	logic i_start;
	logic i_stop;
	logic i_dir;
	microstep_t i_ms;
	step_num_t i_stroke;
	logic i_zpd;
	logic i_xen;
	logic i_xrst;
	logic o_drive;
	logic o_dir;
	microstep_t o_ms;
	logic o_busy;
	step_num_t o_position;
	logic o_tpsign;
	logic o_zpsign;
	logic o_xen;
	logic o_xrst;

	logic [15:0] stim_mem [256];
	int n_tab;
	int n_moves;
	int move_base;
	int cycle_cnt;
	int cycle_limit;
	int value_errs;
	int other_errs;
	int moves_done;
	int tb_errs;
	int m;

	step_motor_top #(
		.C_CLK_DIV(C_CLK_DIV),
		.C_REVERSE_DELAY(C_REVERSE_DELAY),
		.C_INIT_POSITION(C_INIT_POSITION)
	) i_dut (
		.clk(clk), .resetn(resetn),
		.i_acce_wr(i_acce_wr), .i_acce_wr_addr(i_acce_wr_addr),
		.i_acce_wr_data(i_acce_wr_data),
		.i_deac_wr(i_deac_wr), .i_deac_wr_addr(i_deac_wr_addr),
		.i_deac_wr_data(i_deac_wr_data),
		.i_acce_addr_max(i_acce_addr_max), .i_deac_addr_max(i_deac_addr_max),
		.i_speed(i_speed), .i_step(i_step), .i_start(i_start), .i_stop(i_stop),
		.i_dir(i_dir), .i_ms(i_ms), .i_stroke(i_stroke), .i_zpd(i_zpd),
		.i_xen(i_xen), .i_xrst(i_xrst),
		.o_drive(o_drive), .o_dir(o_dir), .o_ms(o_ms), .o_busy(o_busy),
		.o_position(o_position), .o_tpsign(o_tpsign), .o_zpsign(o_zpsign),
		.o_xen(o_xen), .o_xrst(o_xrst)
	);

	step_motor_checker #(
		.C_CLK_DIV(C_CLK_DIV),
		.C_REVERSE_DELAY(C_REVERSE_DELAY)
	) u_checker (
		.clk(clk), .resetn(resetn),
		.i_zpd(i_zpd), .i_xen(i_xen), .i_xrst(i_xrst),
		.i_drive(o_drive), .i_dir(o_dir), .i_ms(o_ms), .i_busy(o_busy),
		.i_position(o_position), .i_tpsign(o_tpsign), .i_zpsign(o_zpsign),
		.i_xen_pass(o_xen), .i_xrst_pass(o_xrst),
		.o_value_errs(value_errs), .o_other_errs(other_errs),
		.o_moves_done(moves_done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycle_cnt);
			$display("** FAIL **");
			$finish;
		end
	end

	// slowest possible step for every move, plus setup and gaps
	function automatic int timeout_cycles();
		int i;
		int base;
		int vmax;
		int steps_sum;
		vmax = 0;
		steps_sum = 0;
		for (i = 0; i < n_tab; i++) begin
			if (stim_mem[5 + 3 * i] > vmax)
				vmax = stim_mem[5 + 3 * i];
			if (stim_mem[6 + 3 * i] > vmax)
				vmax = stim_mem[6 + 3 * i];
		end
		for (i = 0; i < n_moves; i++) begin
			base = move_base + 10 * i;
			if (stim_mem[base + 1] > vmax)
				vmax = stim_mem[base + 1];
			steps_sum += stim_mem[base + 2];
		end
		return steps_sum * 2 * (vmax + 1) * C_CLK_DIV
			+ n_moves * ((C_REVERSE_DELAY + 2) * C_CLK_DIV + C_GAP_MAX + 20)
			+ 3 * n_tab + 200;
	endfunction

	task automatic load_tables();
		int i;
		for (i = 0; i < n_tab; i++) begin
			@(posedge clk);
			i_acce_wr <= 1'b1;
			i_acce_wr_addr <= speed_addr_t'(stim_mem[4 + 3 * i]);
			i_acce_wr_data <= stim_mem[5 + 3 * i];
			i_deac_wr <= 1'b1;
			i_deac_wr_addr <= speed_addr_t'(stim_mem[4 + 3 * i]);
			i_deac_wr_data <= stim_mem[6 + 3 * i];
		end
		@(posedge clk);
		i_acce_wr <= 1'b0;
		i_deac_wr <= 1'b0;
	endtask

	task automatic run_move(input int idx);
		int base;
		int rises;
		int stop_at;
		int zero_at;
		logic last_drive;
		logic stop_sent;
		logic zero_sent;
		base = move_base + 10 * idx;
		stop_at = stim_mem[base + 6];
		zero_at = stim_mem[base + 7];
		@(posedge clk);
		i_speed <= stim_mem[base + 1];
		i_step <= stim_mem[base + 2];
		i_dir <= stim_mem[base + 3][0];
		i_ms <= microstep_t'(stim_mem[base + 4]);
		i_stroke <= stim_mem[base + 5];
		i_xen <= 1'($urandom_range(1, 0));
		i_xrst <= 1'($urandom_range(1, 0));
		@(posedge clk);
		i_start <= 1'b1;
		@(posedge clk);
		i_start <= 1'b0;
		do
			@(negedge clk);
		while (!o_busy);
		rises = 0;
		last_drive = 1'b0;
		stop_sent = 1'b0;
		zero_sent = 1'b0;
		while (o_busy) begin
			@(negedge clk);
			if (o_drive && !last_drive)
				rises++;
			last_drive = o_drive;
			if (stop_at != 0 && rises == stop_at && !stop_sent) begin
				stop_sent = 1'b1;
				@(posedge clk);
				i_stop <= 1'b1;
				@(posedge clk);
				i_stop <= 1'b0;
			end
			// sensor stays high until the move is over
			if (zero_at != 0 && rises == zero_at && !zero_sent) begin
				zero_sent = 1'b1;
				@(posedge clk);
				i_zpd <= 1'b1;
			end
		end
		@(posedge clk);
		i_zpd <= 1'b0;
		repeat ($urandom_range(C_GAP_MAX, 4)) @(posedge clk);
	endtask

	initial begin
		void'($urandom(32'h2248_576b));
		$readmemh("tests/step_motor_stim.txt", stim_mem);
		n_tab = stim_mem[0];
		n_moves = stim_mem[1];
		move_base = 4 + 3 * n_tab;
		cycle_cnt = 0;
		cycle_limit = timeout_cycles();
		tb_errs = 0;
		resetn = 1'b0;
		i_acce_wr = 1'b0;
		i_acce_wr_addr = '0;
		i_acce_wr_data = '0;
		i_deac_wr = 1'b0;
		i_deac_wr_addr = '0;
		i_deac_wr_data = '0;
		i_acce_addr_max = speed_addr_t'(stim_mem[2]);
		i_deac_addr_max = speed_addr_t'(stim_mem[3]);
		i_speed = '0;
		i_step = '0;
		i_start = 1'b0;
		i_stop = 1'b0;
		i_dir = 1'b0;
		i_ms = '0;
		i_stroke = '0;
		i_zpd = 1'b0;
		i_xen = 1'b0;
		i_xrst = 1'b0;
		repeat (3) @(posedge clk);
		resetn <= 1'b1;
		load_tables();
		for (m = 0; m < n_moves; m++)
			run_move(m);
		repeat (10) @(posedge clk);
		if (moves_done != n_moves) begin
			tb_errs++;
			$display("only %0d of %0d moves were completed", moves_done, n_moves);
		end
		$display("errors: %0d value, %0d other", value_errs, other_errs + tb_errs);
		if (value_errs == 0 && other_errs + tb_errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/step_motor_stim.txt
// header: table records, move records, acce addr max, deac addr max
// table: addr acce deac; move: id speed steps dir ms stroke stop zero exp_steps exp_pos
0005 0008 0004 0003
0000 0006 0006
0001 0005 0004
0002 0004 0003
0003 0003 0002
0004 0002 0002
// full moves, speed limit above the tables in the second one
0001 0001 0008 0000 0003 0040 0000 0000 0008 0009
0002 0003 0006 0000 0005 0040 0000 0000 0006 000f
// reversal, then stop edge after three steps
0003 0001 0005 0001 0002 0040 0000 0000 0005 000a
0004 0001 0014 0001 0002 0040 0003 0000 0003 0007
// forward into the stroke end
0005 0001 001e 0000 0007 000c 0000 0000 0006 000c
// zero sensor during a backward move, then saturation at the origin
0006 0002 0028 0001 0001 000c 0000 0004 0004 0001
0007 0001 0003 0001 0000 000c 0000 0000 0003 0001
0008 0001 0001 0000 0004 000c 0000 0000 0001 0002

// File: list.f
hdl/step_motor_pkg.sv
hdl/step_clk_divider.sv
hdl/speed_table.sv
hdl/step_motor_ctrl.sv
hdl/position_tracker.sv
hdl/step_motor_top.sv
tests/step_motor_checker.sv
tests/tb_step_motor.sv

// File: Bender.yml
package:
  name: step_motor

sources:
  - files:
      - hdl/step_motor_pkg.sv
      - hdl/step_clk_divider.sv
      - hdl/speed_table.sv
      - hdl/step_motor_ctrl.sv
      - hdl/position_tracker.sv
      - hdl/step_motor_top.sv
  - target: test
    files:
      - tests/step_motor_checker.sv
      - tests/tb_step_motor.sv
